/* verilog/sha_hub_pkg.sv */
`default_nettype none

package sha_hub_pkg;

  // --------------------
  // basic widths
  typedef logic [31:0]  word_t;   // bus word, also one message word
  typedef logic [511:0] block_t;  // W0 in the top 32 bits
  typedef logic [255:0] hash_t;   // H0 in the top 32 bits

  // system bus, local 20-bit address space
  typedef struct packed {
    logic [19:0] addr;
    word_t       wdata;
    logic        wen;
    logic        ren;
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  ack;
  } bus_rsp_t;

  // register map
  typedef enum logic [19:0] {
    REG_CTRL       = 20'h00000,
    REG_STATUS     = 20'h00004,  // omni status
    REG_VERSION    = 20'h0000C,  // build id, YYMMDDss
    REG_SHA_CTRL   = 20'h00100,
    REG_SHA_STATUS = 20'h00104,
    REG_SHA_PUSH   = 20'h0010C,  // write only
    REG_SHA_HASH   = 20'h00110   // eight words, H7 first
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_ROUND,
    ST_ADD
  } core_state_e;

  localparam word_t BUILD_DATE = 32'h24110701;

  // control bit positions
  localparam int unsigned CTRL_ENABLE    = 0;
  localparam int unsigned SHA_CTRL_RESET = 0;
  localparam int unsigned SHA_CTRL_START = 1;

  // --------------------
  // FIPS 180-4 round constants
  localparam word_t SHA_K [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  localparam hash_t SHA_H_INIT = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

endpackage

`default_nettype wire

/* verilog/block_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module block_fifo #(
  parameter int FIFO_DEPTH = 2  // at least 2
) (
  input  wire                      clk_100mhz,
  input  wire                      rstn_i,   // section reset
  input  wire                      push_i,
  input  wire sha_hub_pkg::block_t block_i,
  input  wire                      pop_i,
  output sha_hub_pkg::block_t      block_o,  // head, valid while not empty
  output logic                     full_o,
  output logic                     afull_o,  // one slot left
  output logic                     empty_o
);

  import sha_hub_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  block_t             mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               do_push;
  logic               do_pop;

  assign do_push = push_i && !full_o;   // push on full is dropped
  assign do_pop  = pop_i && !empty_o;

  // --------------------
  // pointers and occupancy
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (do_push)
      mem_q[wr_ptr_q] <= block_i;
  end

  assign block_o = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign afull_o = (count_q == CNT_W'(FIFO_DEPTH - 1));
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* verilog/sha256_core.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_core (
  input  wire                      clk_100mhz,
  input  wire                      rstn_i,
  input  wire                      empty_i,  // fifo empty
  input  wire sha_hub_pkg::block_t block_i,  // fifo head
  output logic                     pop_o,
  output logic                     ready_o,
  output logic                     done_o,   // sticky until reset
  output sha_hub_pkg::hash_t       hash_o
);

  import sha_hub_pkg::*;

  function automatic word_t rotr(input word_t x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  core_state_e state_q;
  logic [5:0]  round_q;
  word_t       w_q [16];   // sliding schedule, w_q[0] is W[t]
  word_t       v_q [8];    // working vars a..h
  hash_t       hash_q;     // chained H0..H7
  logic        done_q;

  word_t       big_s0;
  word_t       big_s1;
  word_t       ch;
  word_t       maj;
  word_t       t1;
  word_t       t2;
  word_t       small_s0;
  word_t       small_s1;
  word_t       w_next;

  // --------------------
  // round logic
  always_comb begin
    big_s1   = rotr(v_q[4], 6) ^ rotr(v_q[4], 11) ^ rotr(v_q[4], 25);
    ch       = (v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6]);
    t1       = v_q[7] + big_s1 + ch + SHA_K[round_q] + w_q[0];
    big_s0   = rotr(v_q[0], 2) ^ rotr(v_q[0], 13) ^ rotr(v_q[0], 22);
    maj      = (v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]);
    t2       = big_s0 + maj;
    // W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
    small_s0 = rotr(w_q[1], 7) ^ rotr(w_q[1], 18) ^ (w_q[1] >> 3);
    small_s1 = rotr(w_q[14], 17) ^ rotr(w_q[14], 19) ^ (w_q[14] >> 10);
    w_next   = small_s1 + w_q[9] + small_s0 + w_q[0];
  end

  assign pop_o   = (state_q == ST_IDLE) && !empty_i;
  assign ready_o = (state_q == ST_IDLE);
  assign done_o  = done_q;
  assign hash_o  = hash_q;

  // --------------------
  // control FSM
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      state_q <= ST_IDLE;
      round_q <= '0;
      hash_q  <= SHA_H_INIT;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!empty_i)
            state_q <= ST_LOAD;   // popped this cycle
        end
        ST_LOAD: begin
          round_q <= '0;
          state_q <= ST_ROUND;
        end
        ST_ROUND: begin
          round_q <= round_q + 6'd1;
          if (round_q == 6'd63)
            state_q <= ST_ADD;    // 64 rounds done
        end
        ST_ADD: begin
          for (int i = 0; i < 8; i++)
            hash_q[255 - 32*i -: 32] <= hash_q[255 - 32*i -: 32] + v_q[i];
          done_q  <= 1'b1;
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // datapath, no reset
  always_ff @(posedge clk_100mhz) begin
    if (pop_o) begin
      // head is only valid in the pop cycle, schedule takes it here
      for (int i = 0; i < 16; i++)
        w_q[i] <= block_i[511 - 32*i -: 32];
    end else if (state_q == ST_ROUND) begin
      for (int i = 0; i < 15; i++)
        w_q[i] <= w_q[i+1];
      w_q[15] <= w_next;
    end

    if (state_q == ST_LOAD) begin
      for (int i = 0; i < 8; i++)
        v_q[i] <= hash_q[255 - 32*i -: 32];  // a..h from H0..H7
    end else if (state_q == ST_ROUND) begin
      v_q[7] <= v_q[6];
      v_q[6] <= v_q[5];
      v_q[5] <= v_q[4];
      v_q[4] <= v_q[3] + t1;  // e
      v_q[3] <= v_q[2];
      v_q[2] <= v_q[1];
      v_q[1] <= v_q[0];
      v_q[0] <= t1 + t2;      // a
    end
  end

endmodule

`default_nettype wire

/* verilog/sys_bus_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_regs (
  input  wire                       clk_100mhz,
  input  wire                       rstn_i,
  input  wire sha_hub_pkg::bus_req_t bus_req_i,
  output sha_hub_pkg::bus_rsp_t     bus_rsp_o,
  output logic                      activated_o,
  output logic                      sha_rstn_o,
  output sha_hub_pkg::block_t       push_block_o,
  output logic                      push_o,
  input  wire                       fifo_full_i,
  input  wire                       fifo_afull_i,
  input  wire                       fifo_empty_i,
  input  wire                       core_ready_i,
  input  wire                       core_done_i,  // a block was hashed since reset
  input  wire sha_hub_pkg::hash_t   hash_i
);

  import sha_hub_pkg::*;

  word_t       ctrl_q;       // REG_CTRL
  word_t       sha_ctrl_q;   // REG_SHA_CTRL
  logic        omni_rstn_q;  // activated
  logic        sha_rstn_q;   // SHA section enabled
  logic [3:0]  word_cnt_q;   // words of the current block
  block_t      shift_q;      // collector, oldest word ends on top
  logic        push_q;
  bus_rsp_t    rsp_q;

  logic        wr_ctrl;
  logic        wr_sha_ctrl;
  logic        wr_push;
  logic        start_wr;
  logic        hash_valid;
  logic        in_hash;
  logic [19:0] hash_off;
  word_t       status;
  word_t       sha_status;

  // --------------------
  // write decode
  assign wr_ctrl     = bus_req_i.wen && (bus_req_i.addr == REG_CTRL);
  assign wr_sha_ctrl = bus_req_i.wen && (bus_req_i.addr == REG_SHA_CTRL);
  assign wr_push     = bus_req_i.wen && (bus_req_i.addr == REG_SHA_PUSH);
  assign start_wr    = wr_sha_ctrl && bus_req_i.wdata[SHA_CTRL_START];

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
    end else begin
      sha_ctrl_q[SHA_CTRL_START] <= 1'b0;  // one-shot, visible one cycle
      if (wr_ctrl)
        ctrl_q <= bus_req_i.wdata;
      if (wr_sha_ctrl)
        sha_ctrl_q <= bus_req_i.wdata;
    end
  end

  // section resets, one flop stage each
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      omni_rstn_q <= 1'b0;
      sha_rstn_q  <= 1'b0;
    end else begin
      omni_rstn_q <= ctrl_q[CTRL_ENABLE];
      sha_rstn_q  <= omni_rstn_q && !sha_ctrl_q[SHA_CTRL_RESET] && !start_wr;  // start pulse
    end
  end

  // --------------------
  // word collector
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i || start_wr) begin
      word_cnt_q <= '0;
      push_q     <= 1'b0;
    end else begin
      push_q <= wr_push && (word_cnt_q == 4'd15);  // sixteenth word completes a block
      if (wr_push)
        word_cnt_q <= word_cnt_q + 4'd1;           // wraps back to W0
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (wr_push)
      shift_q <= {shift_q[479:0], bus_req_i.wdata};
  end

  // --------------------
  // read side
  assign hash_off   = bus_req_i.addr - REG_SHA_HASH;
  assign in_hash    = (hash_off < 20'd32) && (hash_off[1:0] == 2'b00);
  assign hash_valid = core_done_i && core_ready_i && fifo_empty_i;
  assign status     = {27'd0, sha_rstn_q, 3'd0, omni_rstn_q};
  assign sha_status = {25'd0, fifo_full_i, fifo_afull_i, fifo_empty_i,
                       2'd0, hash_valid, core_ready_i};

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.ack   <= bus_req_i.wen || bus_req_i.ren;  // any address
      rsp_q.rdata <= '0;
      if (bus_req_i.ren) begin
        case (bus_req_i.addr)
          REG_CTRL:       rsp_q.rdata <= ctrl_q;
          REG_STATUS:     rsp_q.rdata <= status;
          REG_VERSION:    rsp_q.rdata <= BUILD_DATE;
          REG_SHA_CTRL:   rsp_q.rdata <= sha_ctrl_q;
          REG_SHA_STATUS: rsp_q.rdata <= sha_status;
          default: begin
            if (in_hash)
              rsp_q.rdata <= hash_i[32*hash_off[4:2] +: 32];  // offset 4k gives H(7-k)
          end
        endcase
      end
    end
  end

  assign bus_rsp_o    = rsp_q;
  assign activated_o  = omni_rstn_q;
  assign sha_rstn_o   = sha_rstn_q;
  assign push_block_o = shift_q;
  assign push_o       = push_q;

endmodule

`default_nettype wire

/* verilog/sha_hub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sha_hub_top #(
  parameter int FIFO_DEPTH = 2  // blocks
) (
  input  wire                       clk_100mhz,
  input  wire                       rstn_i,
  input  wire sha_hub_pkg::bus_req_t bus_req_i,
  output sha_hub_pkg::bus_rsp_t     bus_rsp_o,
  output logic                      activated_o  // omni section out of reset
);

  import sha_hub_pkg::*;

  // --------------------
  // regs -> fifo
  logic   sha_rstn;     // section reset, also pulsed by start
  block_t push_block;
  logic   push;

  // fifo -> core
  block_t head_block;
  logic   fifo_full;
  logic   fifo_afull;
  logic   fifo_empty;
  logic   pop;

  // core -> regs
  logic   core_ready;
  logic   core_done;
  hash_t  hash;

  sys_bus_regs u_sys_bus_regs (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .activated_o  (activated_o),
    .sha_rstn_o   (sha_rstn),
    .push_block_o (push_block),
    .push_o       (push),
    .fifo_full_i  (fifo_full),
    .fifo_afull_i (fifo_afull),
    .fifo_empty_i (fifo_empty),
    .core_ready_i (core_ready),
    .core_done_i  (core_done),
    .hash_i       (hash)
  );

  block_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_block_fifo (
    .clk_100mhz (clk_100mhz),
    .rstn_i     (sha_rstn),
    .push_i     (push),
    .block_i    (push_block),
    .pop_i      (pop),
    .block_o    (head_block),
    .full_o     (fifo_full),
    .afull_o    (fifo_afull),
    .empty_o    (fifo_empty)
  );

  sha256_core u_sha256_core (
    .clk_100mhz (clk_100mhz),
    .rstn_i     (sha_rstn),    // start restarts the chain at H_INIT
    .empty_i    (fifo_empty),
    .block_i    (head_block),
    .pop_o      (pop),
    .ready_o    (core_ready),
    .done_o     (core_done),
    .hash_o     (hash)
  );

endmodule

`default_nettype wire

/* sim/sha_hub_top_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sha_hub_top_assert (
  input wire                        clk_100mhz,
  input wire                        rstn_i,
  input wire                        sha_rstn_i,    // section reset
  input wire sha_hub_pkg::bus_req_t bus_req_i,
  input wire sha_hub_pkg::bus_rsp_t bus_rsp_i,
  input wire                        push_i,        // collector -> fifo strobe
  input wire                        pop_i,
  input wire                        fifo_empty_i,
  input wire sha_hub_pkg::core_state_e core_state_i
);

  import sha_hub_pkg::*;

  int unsigned fail_cnt = 0;

  // --------------------
  // bus ack one cycle after any request, never without one
  a_ack: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    (bus_req_i.wen || bus_req_i.ren) |=> bus_rsp_i.ack)
    else begin
      $error("request not acknowledged one cycle later");
      fail_cnt++;
    end

  a_no_ack: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    !(bus_req_i.wen || bus_req_i.ren) |=> !bus_rsp_i.ack)
    else begin
      $error("acknowledge without a request");
      fail_cnt++;
    end

  // an empty fifo only gets a head block through a push the cycle before
  a_pop: assert property (@(posedge clk_100mhz) disable iff (!sha_rstn_i)
    pop_i |-> (!$past(fifo_empty_i) || $past(push_i)))
    else begin
      $error("block FIFO popped while empty");
      fail_cnt++;
    end

  // 64 rounds, then ST_ADD
  a_rounds: assert property (@(posedge clk_100mhz) disable iff (!sha_rstn_i)
    $rose(core_state_i == ST_ROUND) |-> ##64 (core_state_i != ST_ROUND))
    else begin
      $error("core stayed in ST_ROUND longer than 64 cycles");
      fail_cnt++;
    end

endmodule

bind sha_hub_top sha_hub_top_assert u_sha_hub_top_assert (
  .clk_100mhz   (clk_100mhz),
  .rstn_i       (rstn_i),
  .sha_rstn_i   (sha_rstn),
  .bus_req_i    (bus_req_i),
  .bus_rsp_i    (bus_rsp_o),
  .push_i       (push),
  .pop_i        (pop),
  .fifo_empty_i (fifo_empty),
  .core_state_i (u_sha256_core.state_q)
);

`default_nettype wire

/* sim/tb_sha_hub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sha_hub_top;

  import sha_hub_pkg::*;

  localparam int FIFO_DEPTH  = 2;
  localparam int TEST_CYCLES = 600;                    // rough sum over all tests
  localparam int WATCHDOG_NS = 5 * TEST_CYCLES * 10;
  localparam int MAX_POLLS   = 200;

  // FIPS 180-4 reference digests
  localparam hash_t ABC_DIGEST = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };
  localparam hash_t TWO_BLOCK_DIGEST = {
    32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
    32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
  };
  localparam block_t ABC_BLOCK  = {32'h61626380, 448'd0, 32'h00000018};  // 24 bit message
  localparam block_t TAIL_BLOCK = {480'd0, 32'h000001c0};                // length 448

  logic     clk_100mhz = 1'b0;
  logic     rstn_i;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     activated;
  int       errors = 0;
  int       checks = 0;
  word_t    lcg_state = 32'd1800;

  sha_hub_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sha_hub_top (
    .clk_100mhz  (clk_100mhz),
    .rstn_i      (rstn_i),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .activated_o (activated)
  );

  always #5 clk_100mhz = ~clk_100mhz;  // 100 MHz

  // --------------------
  // helpers
  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // word i of "abcdbcdecdef..." is four letters starting at 'a'+i
  function automatic word_t msg_word(input int i);
    return {8'(97 + i), 8'(98 + i), 8'(99 + i), 8'(100 + i)};
  endfunction

  function automatic block_t two_block_first();
    block_t b;
    b = '0;
    for (int i = 0; i < 14; i++)
      b[511 - 32*i -: 32] = msg_word(i);
    b[63:32] = 32'h80000000;  // pad bit right after the message
    return b;
  endfunction

  // SHA status layout
  function automatic word_t status_word(input logic full, input logic afull, input logic empty,
                                        input logic valid, input logic ready);
    return {25'd0, full, afull, empty, 2'd0, valid, ready};
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_hash(input string name, input hash_t exp, input hash_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // --------------------
  // bus access, one request cycle then wait for ack
  task automatic bus_access(input logic [19:0] addr, input word_t wdata, input logic wen,
                            output bus_rsp_t rsp);
    bus_req_t req;
    int       waited;
    req.addr  = addr;
    req.wdata = wdata;
    req.wen   = wen;
    req.ren   = !wen;
    waited    = 0;
    @(posedge clk_100mhz);
    bus_req <= req;
    @(posedge clk_100mhz);
    bus_req <= '0;
    @(negedge clk_100mhz);
    while (!bus_rsp.ack && waited < 4) begin
      @(negedge clk_100mhz);
      waited++;
    end
    if (!bus_rsp.ack) begin
      errors++;
      $display("No acknowledge for the access to address %h", addr);
    end else if (waited != 0) begin
      errors++;
      $display("Acknowledge for address %h came %0d cycles late", addr, waited);
    end
    rsp = bus_rsp;
  endtask

  task automatic bus_write(input logic [19:0] addr, input word_t wdata);
    bus_rsp_t rsp;
    bus_access(addr, wdata, 1'b1, rsp);
  endtask

  task automatic bus_read(input logic [19:0] addr, output bus_rsp_t rsp);
    bus_access(addr, '0, 1'b0, rsp);
  endtask

  task automatic read_expect(input string name, input logic [19:0] addr, input word_t exp);
    bus_rsp_t rsp;
    bus_read(addr, rsp);
    check_rsp(name, bus_rsp_t'{exp, 1'b1}, rsp);
  endtask

  task automatic start_section();
    bus_write(REG_SHA_CTRL, 32'h1 << SHA_CTRL_START);
  endtask

  // sixteen back-to-back pushes, W0 first
  task automatic push_block(input block_t blk);
    bus_req_t req;
    req.addr = REG_SHA_PUSH;
    req.wen  = 1'b1;
    req.ren  = 1'b0;
    for (int i = 0; i < 16; i++) begin
      req.wdata = blk[511 - 32*i -: 32];
      @(posedge clk_100mhz);
      bus_req <= req;
      @(negedge clk_100mhz);
      if (i > 0 && !bus_rsp.ack) begin  // ack for the previous word
        errors++;
        $display("Push word %0d was not acknowledged", i - 1);
      end
    end
    @(posedge clk_100mhz);
    bus_req <= '0;
    @(negedge clk_100mhz);
    if (!bus_rsp.ack) begin
      errors++;
      $display("Push word 15 was not acknowledged");
    end
  endtask

  task automatic wait_hash_valid(input string name);
    bus_rsp_t rsp;
    int       polls;
    polls = 0;
    bus_read(REG_SHA_STATUS, rsp);
    while (!rsp.rdata[1] && polls < MAX_POLLS) begin
      bus_read(REG_SHA_STATUS, rsp);
      polls++;
    end
    if (!rsp.rdata[1]) begin
      errors++;
      $display("Hash never became valid in %s", name);
    end else begin
      check_word(name, status_word(1'b0, 1'b0, 1'b1, 1'b1, 1'b1), rsp.rdata);
    end
  endtask

  // offset 4k holds H(7-k), so it lands at bits 32k
  task automatic read_hash(output hash_t h);
    bus_rsp_t rsp;
    for (int k = 0; k < 8; k++) begin
      bus_read(20'(REG_SHA_HASH + 4*k), rsp);
      h[32*k +: 32] = rsp.rdata;
    end
  endtask

  // --------------------
  // directed tests
  task automatic reset_identity();
    read_expect("reset_ctrl", REG_CTRL, '0);
    read_expect("reset_sha_ctrl", REG_SHA_CTRL, '0);
    read_expect("reset_status", REG_STATUS, '0);
    read_expect("reset_sha_status", REG_SHA_STATUS,
                status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
    read_expect("version", REG_VERSION, BUILD_DATE);
    read_expect("unmapped", 20'h00200, '0);
    bus_write(REG_VERSION, 32'hdeadbeef);  // read only
    read_expect("version_ro", REG_VERSION, BUILD_DATE);
    bus_write(20'h00008, 32'h12345678);    // hole in the map
    read_expect("unmapped_wr", 20'h00008, '0);
  endtask

  task automatic control_regs();
    word_t v;
    for (int i = 0; i < 6; i++) begin
      v = lcg_next();
      bus_write(REG_CTRL, v);
      read_expect("ctrl_rw", REG_CTRL, v);
    end
    bus_write(REG_CTRL, 32'h1 << CTRL_ENABLE);
    repeat (4) @(posedge clk_100mhz);       // two flop stages to the section reset
    read_expect("status_enabled", REG_STATUS, 32'h11);
    check_word("activated", 32'h1, {31'd0, activated});
    bus_write(REG_SHA_CTRL, 32'h1 << SHA_CTRL_RESET);
    repeat (4) @(posedge clk_100mhz);
    read_expect("status_sha_reset", REG_STATUS, 32'h01);
    bus_write(REG_SHA_CTRL, '0);
    repeat (4) @(posedge clk_100mhz);
    read_expect("status_sha_release", REG_STATUS, 32'h11);
  endtask

  task automatic single_block();
    hash_t h;
    bus_write(REG_CTRL, 32'h1 << CTRL_ENABLE);
    repeat (4) @(posedge clk_100mhz);
    start_section();
    read_expect("start_self_clear", REG_SHA_CTRL, '0);
    push_block(ABC_BLOCK);
    wait_hash_valid("abc_valid");
    read_hash(h);
    check_hash("abc_digest", ABC_DIGEST, h);
  endtask

  task automatic two_block_chain();
    hash_t h;
    start_section();
    push_block(two_block_first());
    push_block(TAIL_BLOCK);                 // queued while block one is hashed
    wait_hash_valid("two_block_valid");
    read_hash(h);
    check_hash("two_block_digest", TWO_BLOCK_DIGEST, h);
  endtask

  // core busy on the first block, later ones pile up in the FIFO
  task automatic fifo_flags();
    start_section();
    push_block(ABC_BLOCK);
    for (int i = 0; i < FIFO_DEPTH - 1; i++)
      push_block(ABC_BLOCK);
    read_expect("fifo_afull", REG_SHA_STATUS, status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    push_block(ABC_BLOCK);
    read_expect("fifo_full", REG_SHA_STATUS, status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    start_section();                        // flushes FIFO and core
    read_expect("fifo_flushed", REG_SHA_STATUS, status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
  endtask

  // --------------------
  initial begin
    int fails;
    rstn_i  = 1'b0;
    bus_req = '0;
    repeat (16) @(posedge clk_100mhz);
    rstn_i <= 1'b1;
    reset_identity();
    control_regs();
    single_block();
    two_block_chain();
    fifo_flags();
    repeat (2) @(posedge clk_100mhz);
    fails = u_sha_hub_top.u_sha_hub_top_assert.fail_cnt;
    $display("Checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, fails);
    if (errors == 0 && fails == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/sha_hub_pkg.sv
verilog/block_fifo.sv
verilog/sha256_core.sv
verilog/sys_bus_regs.sv
verilog/sha_hub_top.sv
sim/sha_hub_top_assert.sv
sim/tb_sha_hub_top.sv

/* Bender.yml */
package:
  name: sha_hub

sources:
  - verilog/sha_hub_pkg.sv
  - verilog/block_fifo.sv
  - verilog/sha256_core.sv
  - verilog/sys_bus_regs.sv
  - verilog/sha_hub_top.sv
  - target: simulation
    files:
      - sim/sha_hub_top_assert.sv
      - sim/tb_sha_hub_top.sv
